/* Makefile */
TOP = tb_decodeStage

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f decodeStage.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f decodeStage.f --top-module $(TOP) -o V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1 || echo "Simulator exited with an error" >> sim.log
	cat sim.log
	@if grep -q "Test failures found" sim.log; then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "All tests passed!" sim.log; then echo "Simulation did not finish"; exit 1; fi
	@echo "Simulation PASSED"

clean:
	rm -rf obj_dir sim.log

/* controlUnit.sv */
`timescale 1ns/1ps
`include "decodeStage_defines.svh"

module controlUnit
    import decodePkg::*;
(
    input  instrWord instr,
    output immSrcT   immSrc,
    ctrlIf.source    ctrl
);
    logic       regWrite;
    logic       aluSrc;
    logic       memWrite;
    logic       branch;
    resultSrcT  resultSrc;
    logic [1:0] aluOp;
    aluCtrlT    aluControl;
    logic       isSub;

    // ====================
    // Main decoder
    // ====================
    always_comb begin
        regWrite  = 1'b0;
        aluSrc    = 1'b0;
        memWrite  = 1'b0;
        branch    = 1'b0;
        resultSrc = RES_ALU;
        immSrc    = IMM_I;
        aluOp     = `ALUOP_MEM;
        case (instr.rView.opcode)
            `OP_LOAD: begin
                regWrite  = 1'b1;
                aluSrc    = 1'b1;
                resultSrc = RES_MEM;
            end
            `OP_STORE: begin
                aluSrc   = 1'b1;
                memWrite = 1'b1;
                immSrc   = IMM_S;
            end
            `OP_RTYPE: begin
                regWrite = 1'b1;
                aluOp    = `ALUOP_FUNCT;
            end
            `OP_ITYPE: begin
                regWrite = 1'b1;
                aluSrc   = 1'b1;
                aluOp    = `ALUOP_FUNCT;
            end
            `OP_BRANCH: begin
                branch = 1'b1;
                immSrc = IMM_B;
                aluOp  = `ALUOP_BRANCH;  // beq compares by subtraction
            end
            default: begin
                // Unsupported opcode leaves every control at zero
            end
        endcase
    end

    // ====================
    // ALU decoder
    // ====================
    assign isSub = (instr.rView.opcode == `OP_RTYPE) && instr.rView.funct7[5];  // addi never subtracts

    always_comb begin
        case (aluOp)
            `ALUOP_BRANCH: aluControl = SUB;
            `ALUOP_FUNCT: begin
                case (instr.rView.funct3)
                    3'b000:  aluControl = isSub ? SUB : ADD;
                    3'b010:  aluControl = SLT;
                    3'b110:  aluControl = OR;
                    3'b111:  aluControl = AND;
                    default: aluControl = ADD;
                endcase
            end
            default: aluControl = ADD;
        endcase
    end

    assign ctrl.regWrite   = regWrite;
    assign ctrl.aluSrc     = aluSrc;
    assign ctrl.memWrite   = memWrite;
    assign ctrl.branch     = branch;
    assign ctrl.resultSrc  = resultSrc;
    assign ctrl.aluControl = aluControl;
endmodule

/* ctrlIf.sv */
`timescale 1ns/1ps

// Control bundle from the decoder to the ID/EX register
interface ctrlIf
    import decodePkg::*;
();
    logic      regWrite;
    logic      aluSrc;
    logic      memWrite;
    logic      branch;
    resultSrcT resultSrc;
    aluCtrlT   aluControl;

    modport source (
        output regWrite,
        output aluSrc,
        output memWrite,
        output branch,
        output resultSrc,
        output aluControl
    );

    modport sink (
        input regWrite,
        input aluSrc,
        input memWrite,
        input branch,
        input resultSrc,
        input aluControl
    );
endinterface

/* decodePkg.sv */
`include "decodeStage_defines.svh"

package decodePkg;

    // ====================
    // Instruction word
    // ====================

    // R-type field layout that also gives rs1, rs2 and rd for every format
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rFieldsT;

    // Store layout where the immediate is split around the register fields
    typedef struct packed {
        logic [6:0] immHi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] immLo;
        logic [6:0] opcode;
    } sFieldsT;

    typedef union packed {
        rFieldsT rView;
        sFieldsT sView;
    } instrWord;

    // ====================
    // Control fields
    // ====================
    typedef enum logic [1:0] {
        IMM_I = 2'b00,
        IMM_S = 2'b01,
        IMM_B = 2'b10
    } immSrcT;

    typedef enum logic [2:0] {
        ADD = `ALU_ADD,
        SUB = `ALU_SUB,
        AND = `ALU_AND,
        OR  = `ALU_OR,
        SLT = `ALU_SLT
    } aluCtrlT;

    typedef enum logic [1:0] {
        RES_ALU = 2'b00,
        RES_MEM = 2'b01,
        RES_PC4 = 2'b10  // Reserved for jumps
    } resultSrcT;

endpackage

/* decodeStage.f */
+incdir+.
decodePkg.sv
ctrlIf.sv
controlUnit.sv
registerFile.sv
immExtend.sv
idExRegister.sv
decodeStage.sv
decodeStage_sva.sv
tb_decodeStage.sv

/* decodeStage.sv */
`timescale 1ns/1ps
`include "decodeStage_defines.svh"

module decodeStage
    import decodePkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic             flushE,
    input  logic             regWriteW,
    input  logic [4:0]       rdW,
    input  logic [`XLEN-1:0] resultW,
    input  instrWord         instrD,
    input  logic [`XLEN-1:0] pcD,
    input  logic [`XLEN-1:0] pcPlus4D,
    output logic             regWriteE,
    output logic             aluSrcE,
    output logic             memWriteE,
    output logic             branchE,
    output resultSrcT        resultSrcE,
    output aluCtrlT          aluControlE,
    output logic [`XLEN-1:0] rd1E,
    output logic [`XLEN-1:0] rd2E,
    output logic [`XLEN-1:0] immExtE,
    output logic [4:0]       rs1E,
    output logic [4:0]       rs2E,
    output logic [4:0]       rdE,
    output logic [`XLEN-1:0] pcE,
    output logic [`XLEN-1:0] pcPlus4E
);
    immSrcT           immSrcD;
    logic [`XLEN-1:0] rd1D;
    logic [`XLEN-1:0] rd2D;
    logic [`XLEN-1:0] immExtD;

    ctrlIf ctrlD ();

    // ====================
    // Decode
    // ====================
    controlUnit uControl (
        .instr  (instrD),
        .immSrc (immSrcD),
        .ctrl   (ctrlD)
    );

    registerFile uRegFile (
        .clk    (clk),
        .rst    (rst),
        .we     (regWriteW),
        .wAddr  (rdW),
        .wData  (resultW),
        .rAddr1 (instrD.rView.rs1),
        .rAddr2 (instrD.rView.rs2),
        .rData1 (rd1D),
        .rData2 (rd2D)
    );

    immExtend uImm (
        .instr  (instrD),
        .immSrc (immSrcD),
        .immExt (immExtD)
    );

    // ====================
    // ID/EX boundary
    // ====================
    idExRegister uIdEx (
        .clk         (clk),
        .rst         (rst),
        .flush       (flushE),
        .ctrl        (ctrlD),
        .rd1         (rd1D),
        .rd2         (rd2D),
        .immExt      (immExtD),
        .pc          (pcD),
        .pcPlus4     (pcPlus4D),
        .rs1         (instrD.rView.rs1),
        .rs2         (instrD.rView.rs2),
        .rd          (instrD.rView.rd),
        .regWriteE   (regWriteE),
        .aluSrcE     (aluSrcE),
        .memWriteE   (memWriteE),
        .branchE     (branchE),
        .resultSrcE  (resultSrcE),
        .aluControlE (aluControlE),
        .rd1E        (rd1E),
        .rd2E        (rd2E),
        .immExtE     (immExtE),
        .pcE         (pcE),
        .pcPlus4E    (pcPlus4E),
        .rs1E        (rs1E),
        .rs2E        (rs2E),
        .rdE         (rdE)
    );
endmodule

/* decodeStage_defines.svh */
`ifndef DECODESTAGE_DEFINES_SVH
`define DECODESTAGE_DEFINES_SVH

// ====================
// Datapath sizes
// ====================
`define XLEN      32
`define REG_COUNT 32

// ====================
// RV32I opcodes
// ====================
`define OP_LOAD   7'b0000011
`define OP_STORE  7'b0100011
`define OP_RTYPE  7'b0110011
`define OP_ITYPE  7'b0010011
`define OP_BRANCH 7'b1100011

// ALU control codes seen by the execute stage
`define ALU_ADD 3'b000
`define ALU_SUB 3'b001
`define ALU_AND 3'b010
`define ALU_OR  3'b011
`define ALU_SLT 3'b101

// ALU operation class from the main decoder
`define ALUOP_MEM    2'b00
`define ALUOP_BRANCH 2'b01
`define ALUOP_FUNCT  2'b10

`endif

/* decodeStage_sva.sv */
`timescale 1ns/1ps
`include "decodeStage_defines.svh"

module decodeStageSva (
    input logic               clk,
    input logic               rst,
    input logic               flushE,
    input logic [4:0]         rs1E,
    input logic [4:0]         rs2E,
    input logic [`XLEN-1:0]   rd1E,
    input logic [`XLEN-1:0]   rd2E,
    input logic [5*`XLEN+23:0] allE  // Every E output side by side
);
    int failCount = 0;

    assert property (@(posedge clk) !rst |-> allE == '0)
        else begin
            failCount++;
            $error("E outputs not cleared during reset");
        end

    // A flushed edge leaves a bubble behind it
    assert property (@(posedge clk) disable iff (!rst) flushE |=> allE == '0)
        else begin
            failCount++;
            $error("E outputs not cleared after flush");
        end

    assert property (@(posedge clk) disable iff (!rst) rs1E == 5'd0 |-> rd1E == '0)
        else begin
            failCount++;
            $error("rd1E not zero for x0");
        end
    assert property (@(posedge clk) disable iff (!rst) rs2E == 5'd0 |-> rd2E == '0)
        else begin
            failCount++;
            $error("rd2E not zero for x0");
        end
endmodule

bind decodeStage decodeStageSva uSva (
    .clk    (clk),
    .rst    (rst),
    .flushE (flushE),
    .rs1E   (rs1E),
    .rs2E   (rs2E),
    .rd1E   (rd1E),
    .rd2E   (rd2E),
    .allE   ({regWriteE, aluSrcE, memWriteE, branchE, resultSrcE, aluControlE,
              rd1E, rd2E, immExtE, pcE, pcPlus4E, rs1E, rs2E, rdE})
);

/* idExRegister.sv */
`timescale 1ns/1ps
`include "decodeStage_defines.svh"

module idExRegister
    import decodePkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic             flush,
    ctrlIf.sink              ctrl,
    input  logic [`XLEN-1:0] rd1,
    input  logic [`XLEN-1:0] rd2,
    input  logic [`XLEN-1:0] immExt,
    input  logic [`XLEN-1:0] pc,
    input  logic [`XLEN-1:0] pcPlus4,
    input  logic [4:0]       rs1,
    input  logic [4:0]       rs2,
    input  logic [4:0]       rd,
    output logic             regWriteE,
    output logic             aluSrcE,
    output logic             memWriteE,
    output logic             branchE,
    output resultSrcT        resultSrcE,
    output aluCtrlT          aluControlE,
    output logic [`XLEN-1:0] rd1E,
    output logic [`XLEN-1:0] rd2E,
    output logic [`XLEN-1:0] immExtE,
    output logic [`XLEN-1:0] pcE,
    output logic [`XLEN-1:0] pcPlus4E,
    output logic [4:0]       rs1E,
    output logic [4:0]       rs2E,
    output logic [4:0]       rdE
);
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            regWriteE   <= 1'b0;
            aluSrcE     <= 1'b0;
            memWriteE   <= 1'b0;
            branchE     <= 1'b0;
            resultSrcE  <= RES_ALU;
            aluControlE <= ADD;
            rd1E        <= '0;
            rd2E        <= '0;
            immExtE     <= '0;
            pcE         <= '0;
            pcPlus4E    <= '0;
            rs1E        <= '0;
            rs2E        <= '0;
            rdE         <= '0;
        end else if (flush) begin  // Bubble with every field cleared
            regWriteE   <= 1'b0;
            aluSrcE     <= 1'b0;
            memWriteE   <= 1'b0;
            branchE     <= 1'b0;
            resultSrcE  <= RES_ALU;
            aluControlE <= ADD;
            rd1E        <= '0;
            rd2E        <= '0;
            immExtE     <= '0;
            pcE         <= '0;
            pcPlus4E    <= '0;
            rs1E        <= '0;
            rs2E        <= '0;
            rdE         <= '0;
        end else begin
            regWriteE   <= ctrl.regWrite;
            aluSrcE     <= ctrl.aluSrc;
            memWriteE   <= ctrl.memWrite;
            branchE     <= ctrl.branch;
            resultSrcE  <= ctrl.resultSrc;
            aluControlE <= ctrl.aluControl;
            rd1E        <= rd1;
            rd2E        <= rd2;
            immExtE     <= immExt;
            pcE         <= pc;
            pcPlus4E    <= pcPlus4;
            rs1E        <= rs1;
            rs2E        <= rs2;
            rdE         <= rd;
        end
    end
endmodule

/* immExtend.sv */
`timescale 1ns/1ps
`include "decodeStage_defines.svh"

module immExtend
    import decodePkg::*;
(
    input  instrWord         instr,
    input  immSrcT           immSrc,
    output logic [`XLEN-1:0] immExt
);
    logic signBit;

    assign signBit = instr.sView.immHi[6];  // Bit 31 in every format

    always_comb begin
        case (immSrc)
            IMM_I: immExt = {{(`XLEN-12){signBit}}, instr.sView.immHi, instr.sView.rs2};
            IMM_S: immExt = {{(`XLEN-12){signBit}}, instr.sView.immHi, instr.sView.immLo};
            IMM_B: begin
                // Branch offset is in halfwords so bit 0 is always clear
                immExt = {{(`XLEN-12){signBit}},
                          instr.sView.immLo[0],
                          instr.sView.immHi[5:0],
                          instr.sView.immLo[4:1],
                          1'b0};
            end
            default: immExt = '0;
        endcase
    end
endmodule

/* registerFile.sv */
`timescale 1ns/1ps
`include "decodeStage_defines.svh"

module registerFile (
    input  logic               clk,
    input  logic               rst,
    input  logic               we,
    input  logic [4:0]         wAddr,
    input  logic [`XLEN-1:0]   wData,
    input  logic [4:0]         rAddr1,
    input  logic [4:0]         rAddr2,
    output logic [`XLEN-1:0]   rData1,
    output logic [`XLEN-1:0]   rData2
);
    logic [`XLEN-1:0] regs [`REG_COUNT];

    // Write port is driven by writeback
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (wAddr != 5'd0)) begin  // x0 is never written
            regs[wAddr] <= wData;
        end
    end

    // Reads see the stored array only, so a same-cycle write shows up next cycle
    assign rData1 = regs[rAddr1];
    assign rData2 = regs[rAddr2];
endmodule

/* tb_decodeStage.sv */
`timescale 1ns/1ps
`include "decodeStage_defines.svh"

module tb_decodeStage
    import decodePkg::*;
();
    typedef struct packed {
        logic             regWrite;
        logic             aluSrc;
        logic             memWrite;
        logic             branch;
        resultSrcT        resultSrc;
        aluCtrlT          aluControl;
        logic [`XLEN-1:0] rd1;
        logic [`XLEN-1:0] rd2;
        logic [`XLEN-1:0] imm;
        logic [4:0]       rs1;
        logic [4:0]       rs2;
        logic [4:0]       rd;
        logic [`XLEN-1:0] pc;
        logic [`XLEN-1:0] pcPlus4;
    } expectT;

    logic clk, rst, flushE, regWriteW;
    logic [4:0] rdW;
    logic [`XLEN-1:0] resultW, pcD, pcPlus4D;
    instrWord instrD;
    logic regWriteE, aluSrcE, memWriteE, branchE;
    resultSrcT resultSrcE;
    aluCtrlT aluControlE;
    logic [`XLEN-1:0] rd1E, rd2E, immExtE, pcE, pcPlus4E;
    logic [4:0] rs1E, rs2E, rdE;

    integer seed;
    int errors;
    int checks;
    logic [`XLEN-1:0] modelRegs [`REG_COUNT];
    expectT pending;
    logic pendingValid;
    logic [6:0] decodeOps [6] = '{`OP_LOAD, `OP_STORE, `OP_RTYPE, `OP_ITYPE, `OP_BRANCH,
                                  7'b1101111};

    decodeStage i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ====================
    // Reference model
    // ====================
    function automatic aluCtrlT aluFor(input logic [2:0] f3, input logic sub);
        case (f3)
            3'b000:  return sub ? SUB : ADD;
            3'b010:  return SLT;
            3'b110:  return OR;
            3'b111:  return AND;
            default: return ADD;
        endcase
    endfunction

    function automatic expectT predict(input logic [31:0] w, input logic [31:0] pc,
                                       input logic flush);
        expectT e;
        e = '0;
        if (flush) return e;  // Bubble
        e.rs1 = w[19:15];
        e.rs2 = w[24:20];
        e.rd = w[11:7];
        e.rd1 = modelRegs[w[19:15]];  // Value before any write of this cycle
        e.rd2 = modelRegs[w[24:20]];
        e.pc = pc;
        e.pcPlus4 = pc + 32'd4;
        e.imm = {{20{w[31]}}, w[31:20]};
        case (w[6:0])
            `OP_LOAD: begin
                e.regWrite = 1'b1;
                e.aluSrc = 1'b1;
                e.resultSrc = RES_MEM;
            end
            `OP_STORE: begin
                e.aluSrc = 1'b1;
                e.memWrite = 1'b1;
                e.imm = {{20{w[31]}}, w[31:25], w[11:7]};
            end
            `OP_BRANCH: begin
                e.branch = 1'b1;
                e.aluControl = SUB;
                e.imm = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            end
            `OP_RTYPE, `OP_ITYPE: begin
                e.regWrite = 1'b1;
                e.aluSrc = (w[6:0] == `OP_ITYPE);
                e.aluControl = aluFor(w[14:12], (w[6:0] == `OP_RTYPE) && w[30]);
            end
            default: begin
                // Illegal opcode keeps every control at zero
            end
        endcase
        return e;
    endfunction

    function automatic logic [6:0] pickOpcode();
        logic [31:0] r;
        r = $random(seed);
        if (r[11:8] > 4'd1) return decodeOps[r[11:8] % 5];
        if (r[6:0] inside {`OP_LOAD, `OP_STORE, `OP_RTYPE, `OP_ITYPE, `OP_BRANCH})
            return r[6:0] ^ 7'b0001000;  // Moves a legal opcode off the table
        return r[6:0];
    endfunction

    // ====================
    // Checks
    // ====================
    task automatic checkCtrl(input logic [3:0] gotFlags, input logic [3:0] expFlags,
                             input resultSrcT gotRes, input resultSrcT expRes,
                             input aluCtrlT gotAlu, input aluCtrlT expAlu);
        checks++;
        if (gotFlags !== expFlags || gotRes !== expRes || gotAlu !== expAlu) begin
            errors++;
            $display("FAIL at %0d ns: controls got %b/%0d/%0d expected %b/%0d/%0d",
                     $time, gotFlags, gotRes, gotAlu, expFlags, expRes, expAlu);
        end
    endtask

    task automatic checkData(input string name, input logic [`XLEN-1:0] got,
                             input logic [`XLEN-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL at %0d ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic checkAddr(input string name, input logic [4:0] got, input logic [4:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL at %0d ns: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic compareAll(input expectT e);
        checkCtrl({regWriteE, aluSrcE, memWriteE, branchE},
                  {e.regWrite, e.aluSrc, e.memWrite, e.branch},
                  resultSrcE, e.resultSrc, aluControlE, e.aluControl);
        checkData("rd1E", rd1E, e.rd1);
        checkData("rd2E", rd2E, e.rd2);
        checkData("immExtE", immExtE, e.imm);
        checkData("pcE", pcE, e.pc);
        checkData("pcPlus4E", pcPlus4E, e.pcPlus4);
        checkAddr("rs1E", rs1E, e.rs1);
        checkAddr("rs2E", rs2E, e.rs2);
        checkAddr("rdE", rdE, e.rd);
    endtask

    // ====================
    // Stimulus
    // ====================
    task automatic runCycle(input logic [31:0] w, input logic flush, input logic we,
                            input logic [4:0] wa, input logic [31:0] wd);
        logic [31:0] pc;
        expectT next;
        pc = $random(seed);
        pc[1:0] = 2'b00;
        @(posedge clk);
        instrD    <= w;
        pcD       <= pc;
        pcPlus4D  <= pc + 32'd4;
        flushE    <= flush;
        regWriteW <= we;
        rdW       <= wa;
        resultW   <= wd;
        next = predict(w, pc, flush);
        if (we && wa != 5'd0) modelRegs[wa] = wd;  // Lands on the same edge as the read
        if (pendingValid) begin
            @(negedge clk);
            compareAll(pending);
        end
        pending = next;
        pendingValid = 1'b1;
    endtask

    task automatic drainPending();
        @(posedge clk);
        regWriteW <= 1'b0;
        flushE    <= 1'b0;
        if (pendingValid) begin
            @(negedge clk);
            compareAll(pending);
        end
        pendingValid = 1'b0;
    endtask

    task automatic runTest(input string name, input int kind, input int n);
        logic [31:0] w;
        logic [31:0] r;
        int startErrors;
        startErrors = errors;
        for (int i = 0; i < n; i++) begin
            r = $random(seed);
            w = $random(seed);
            w[6:0] = pickOpcode();
            case (kind)
                0: begin  // Sweep every register
                    w[19:15] = i[4:0];
                    w[24:20] = ~i[4:0];
                    runCycle(w, 1'b0, 1'b0, 5'd0, 32'd0);
                end
                1: begin
                    if (r[8:7] == 2'b00) w[19:15] = r[4:0];
                    if (r[10:9] == 2'b00) w[24:20] = r[4:0];
                    runCycle(w, 1'b0, r[5] | r[6], r[4:0], $random(seed));
                end
                2: begin
                    w[6:0] = decodeOps[i / 16];
                    w[14:12] = i[3:1];
                    w[30] = i[0];
                    runCycle(w, 1'b0, 1'b0, 5'd0, 32'd0);
                end
                3: runCycle(w, 1'b0, 1'b0, 5'd0, 32'd0);
                4: runCycle(w, r[1:0] == 2'b00, r[2], r[7:3], $random(seed));
                default: begin
                    w[19:15] = 5'd0;  // x0 is written every cycle and read back
                    if (r[0]) w[24:20] = 5'd0;
                    runCycle(w, 1'b0, 1'b1, 5'd0, $random(seed));
                end
            endcase
        end
        drainPending();
        $display("Test %s finished with %0d errors", name, errors - startErrors);
    endtask

    initial begin
        seed = 32'h6af3824a;
        errors = 0;
        checks = 0;
        pendingValid = 1'b0;
        rst = 1'b0;
        flushE = 1'b0;
        regWriteW = 1'b0;
        rdW = 5'd0;
        resultW = '0;
        instrD = '0;
        pcD = '0;
        pcPlus4D = '0;
        for (int i = 0; i < `REG_COUNT; i++) modelRegs[i] = '0;
        for (int i = 0; i < 10; i++) begin
            @(negedge clk);
            compareAll('0);  // Everything held clear in reset
        end
        @(posedge clk);
        rst <= 1'b1;
        runTest("reset", 0, 32);
        runTest("register write and read", 1, 80);
        runTest("register contents", 0, 32);
        runTest("control decode", 2, 96);
        runTest("immediates", 3, 60);
        runTest("flush", 4, 80);
        runTest("x0", 5, 24);
        errors += i_dut.uSva.failCount;
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end
endmodule
